// File: rtl/r24bb_settings.svh
`ifndef R24BB_SETTINGS_SVH
`define R24BB_SETTINGS_SVH

// Bus widths
`define R24BB_DW        32      // APB and USB data
`define R24BB_BE_W      4       // USB byte enables
`define R24BB_SAMPLE_W  8       // ADC sample
`define R24BB_IOEXP_W   16      // Two expander ports
`define R24BB_LED_DEPTH 16      // Delta-sigma accumulator

// Register page, upper 20 address bits
`define R24BB_PAGE      20'h43C04

// Timing
`define R24BB_DOR_HOLD  16      // Overrange stretch in clk cycles
`define R24BB_SCL_DIV   4       // clk cycles per quarter bit

// Expander bus address, 7 bit
`define R24BB_IOEXP_ADDR 7'h20

`endif

// File: rtl/r24bb_pkg.sv
package r24bb_pkg;

    // Register offsets inside the page
    typedef enum logic [7:0] {
        REG_CTRL     = 8'h00,   // USB source in [1:0]
        REG_ADC_CHAN = 8'h04,   // att [1:0], amp_en [2], led [5:3]
        REG_LED0     = 8'h08,   // Brightness
        REG_LED1     = 8'h0C,
        REG_USB_TX   = 8'h10,   // Write only, pushes a word
        REG_USB_RX   = 8'h14,   // Read pops a word
        REG_STATUS   = 8'h18    // Read only
    } reg_addr_e;

    // What feeds the USB write FIFO
    typedef enum logic [1:0] {
        USB_SRC_REGS = 2'd0,
        USB_SRC_IDLE = 2'd1,
        USB_SRC_ADC  = 2'd2,
        USB_SRC_LOOP = 2'd3
    } usb_src_e;

    // Expander serializer
    typedef enum logic [1:0] {
        IDLE,
        START,
        BITS,
        STOP
    } ioexp_state_e;

endpackage

// File: rtl/r24bb_regs.sv
`timescale 1ns/1ps
`include "r24bb_settings.svh"

module r24bb_regs (
    input  logic                          clk,
    input  logic                          rst_n_i,
    // APB slave
    input  logic                          apb_psel_i,
    input  logic                          apb_penable_i,
    input  logic                          apb_pwrite_i,
    input  logic [`R24BB_DW-1:0]          apb_paddr_i,
    input  logic [`R24BB_DW-1:0]          apb_pwdata_i,
    output logic [`R24BB_DW-1:0]          apb_prdata_o,
    // Status sources
    input  logic [`R24BB_DW-1:0]          usb_rd_data_i,
    input  logic                          usb_wr_full_i,
    input  logic                          usb_rd_empty_i,
    input  logic                          adc_ovr_i,
    // Settings out
    output r24bb_pkg::usb_src_e           usb_src_o,
    output logic [`R24BB_DW-1:0]          usb_tx_data_o,
    output logic                          usb_tx_en_o,
    output logic                          usb_rx_pop_o,
    output logic [1:0]                    att_o,
    output logic                          amp_en_o,
    output logic [2:0]                    led_o,
    output logic [`R24BB_LED_DEPTH-1:0]   led0_level_o,
    output logic [`R24BB_LED_DEPTH-1:0]   led1_level_o
);
    import r24bb_pkg::*;

    logic      page_hit;    // Upper address matches
    logic      off_hit;     // Inside first 256 bytes of page
    reg_addr_e offset;
    logic      wr_acc;
    logic      rd_acc;
    logic [5:0] adc_chan_q; // {led, amp_en, att}

    //////////////////////////////
    // Decode
    //////////////////////////////
    assign page_hit = (apb_paddr_i[`R24BB_DW-1:12] == `R24BB_PAGE);
    assign off_hit  = page_hit && (apb_paddr_i[11:8] == 4'h0);
    assign offset   = reg_addr_e'(apb_paddr_i[7:0]);
    assign wr_acc   = apb_psel_i && apb_penable_i && apb_pwrite_i && off_hit;
    assign rd_acc   = apb_psel_i && apb_penable_i && !apb_pwrite_i && off_hit;

    // Pop only during the access cycle
    assign usb_rx_pop_o = rd_acc && (offset == REG_USB_RX);

    //////////////////////////////
    // Register writes
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            usb_src_o     <= USB_SRC_REGS;
            adc_chan_q    <= '0;
            led0_level_o  <= '0;
            led1_level_o  <= '0;
            usb_tx_data_o <= '0;
            usb_tx_en_o   <= 1'b0;
        end else begin
            usb_tx_en_o <= 1'b0;                // Single cycle push
            if (wr_acc) begin
                case (offset)
                    REG_CTRL:     usb_src_o    <= usb_src_e'(apb_pwdata_i[1:0]);
                    REG_ADC_CHAN: adc_chan_q   <= apb_pwdata_i[5:0];
                    REG_LED0:     led0_level_o <= apb_pwdata_i[`R24BB_LED_DEPTH-1:0];
                    REG_LED1:     led1_level_o <= apb_pwdata_i[`R24BB_LED_DEPTH-1:0];
                    REG_USB_TX: begin
                        usb_tx_data_o <= apb_pwdata_i;
                        usb_tx_en_o   <= 1'b1;
                    end
                    default: ;                  // RX and STATUS are read only
                endcase
            end
        end
    end

    assign att_o    = adc_chan_q[1:0];
    assign amp_en_o = adc_chan_q[2];
    assign led_o    = adc_chan_q[5:3];

    //////////////////////////////
    // Read mux
    //////////////////////////////
    always_comb begin
        apb_prdata_o = '0;
        if (rd_acc) begin
            case (offset)
                REG_CTRL:     apb_prdata_o[1:0] = usb_src_o;
                REG_ADC_CHAN: apb_prdata_o[5:0] = adc_chan_q;
                REG_LED0:     apb_prdata_o[`R24BB_LED_DEPTH-1:0] = led0_level_o;
                REG_LED1:     apb_prdata_o[`R24BB_LED_DEPTH-1:0] = led1_level_o;
                REG_USB_RX:   apb_prdata_o = usb_rd_data_i;
                REG_STATUS:   apb_prdata_o[2:0] = {adc_ovr_i, usb_rd_empty_i, usb_wr_full_i};
                default: ;                      // TX and holes read zero
            endcase
        end
    end

endmodule

// File: rtl/usb_route.sv
`timescale 1ns/1ps

module usb_route #(
    parameter int DW       = 32,
    parameter int BE_W     = 4,
    parameter int SAMPLE_W = 8
) (
    input  r24bb_pkg::usb_src_e usb_src_i,
    input  logic [DW-1:0]       tx_data_i,      // From register block
    input  logic                tx_en_i,
    input  logic                rx_pop_i,
    input  logic [SAMPLE_W-1:0] sample_i,       // Registered ADC sample
    input  logic [DW-1:0]       usb_rd_data_i,
    input  logic [BE_W-1:0]     usb_rd_be_i,
    input  logic                usb_rd_valid_i,
    input  logic                usb_wr_full_i,
    output logic [DW-1:0]       usb_wr_data_o,
    output logic [BE_W-1:0]     usb_wr_be_o,
    output logic                usb_wr_en_o,
    output logic                usb_rd_en_o
);
    import r24bb_pkg::*;

    // Pure mux, no latency
    always_comb begin
        usb_wr_data_o = '0;
        usb_wr_be_o   = '1;     // Full words unless looping
        usb_wr_en_o   = 1'b0;
        usb_rd_en_o   = 1'b0;
        case (usb_src_i)
            USB_SRC_REGS: begin
                usb_wr_data_o = tx_data_i;
                usb_wr_en_o   = tx_en_i;
                usb_rd_en_o   = rx_pop_i;
            end
            USB_SRC_ADC: begin                  // Stream every cycle
                usb_wr_data_o = {{(DW - SAMPLE_W){1'b0}}, sample_i};
                usb_wr_en_o   = 1'b1;
                usb_rd_en_o   = 1'b1;
            end
            USB_SRC_LOOP: begin
                usb_wr_data_o = usb_rd_data_i;
                usb_wr_be_o   = usb_rd_be_i;
                usb_wr_en_o   = usb_rd_valid_i;
                usb_rd_en_o   = !usb_wr_full_i; // Stall on full
            end
            default: ;                          // IDLE keeps defaults
        endcase
    end

endmodule

// File: rtl/adc_front.sv
`timescale 1ns/1ps
`include "r24bb_settings.svh"

module adc_front (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [`R24BB_SAMPLE_W-1:0]  adc_data_i,
    input  logic                        adc_dor_i,      // Overrange pulse
    input  logic [1:0]                  att_i,
    input  logic                        amp_en_i,
    input  logic [2:0]                  led_i,          // {red, green, blue}
    output logic [`R24BB_SAMPLE_W-1:0]  sample_o,
    output logic                        ovr_o,          // Stretched overrange
    output logic [`R24BB_IOEXP_W-1:0]   ioexp_word_o
);
    localparam int HOLD_W = $clog2(`R24BB_DOR_HOLD + 1);

    logic [HOLD_W-1:0]          hold_cnt;
    logic [2:0]                 led_eff;
    logic [`R24BB_IOEXP_W-1:0]  word_d;

    // Sample and expander word pipeline
    always_ff @(posedge clk) begin
        sample_o     <= adc_data_i;
        ioexp_word_o <= word_d;
    end

    // Reload on every dor, count down to zero
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hold_cnt <= '0;
        end else if (adc_dor_i) begin
            hold_cnt <= HOLD_W'(`R24BB_DOR_HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign ovr_o = (hold_cnt != '0);

    // Red only while overrange is held
    assign led_eff = ovr_o ? 3'b100 : led_i;

    // Expander pins are active low for att and LEDs
    always_comb begin
        word_d       = '0;
        word_d[1:0]  = ~att_i;
        word_d[2]    = amp_en_i;
        word_d[10:8] = ~led_eff;    // Port 1 low bits
    end

endmodule

// File: rtl/ioexp_serial.sv
`timescale 1ns/1ps
`include "r24bb_settings.svh"

module ioexp_serial (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [`R24BB_IOEXP_W-1:0]   word_i,
    output logic                        scl_o,
    output logic                        sda_o
);
    import r24bb_pkg::*;

    localparam int FRAME_BITS = 3 * 9;     // Address, port 0, port 1, each with ack slot
    localparam int QW = $clog2(`R24BB_SCL_DIV + 1);
    localparam int BW = $clog2(FRAME_BITS + 1);

    ioexp_state_e              state;
    logic [QW-1:0]             q_cnt;       // clk cycles inside a quarter
    logic [1:0]                ph;          // Quarter inside a bit
    logic [BW-1:0]             bit_cnt;
    logic [FRAME_BITS-1:0]     shift_q;
    logic [`R24BB_IOEXP_W-1:0] last_q;      // Last word sent
    logic                      pending;     // Forces first frame
    logic                      scl_d;
    logic                      sda_d;

    //////////////////////////////
    // Sequencer
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state   <= IDLE;
            q_cnt   <= '0;
            ph      <= '0;
            bit_cnt <= '0;
            shift_q <= '0;
            last_q  <= '0;
            pending <= 1'b1;
            scl_o   <= 1'b1;
            sda_o   <= 1'b1;
        end else begin
            scl_o <= scl_d;
            sda_o <= sda_d;
            if (state == IDLE) begin
                q_cnt   <= '0;
                ph      <= '0;
                bit_cnt <= '0;
                if (pending || (word_i != last_q)) begin
                    // Ack slots sent as released high
                    shift_q <= {`R24BB_IOEXP_ADDR, 1'b0, 1'b1,
                                word_i[7:0], 1'b1,
                                word_i[`R24BB_IOEXP_W-1:8], 1'b1};
                    last_q  <= word_i;
                    pending <= 1'b0;
                    state   <= START;
                end
            end else if (q_cnt == QW'(`R24BB_SCL_DIV - 1)) begin
                q_cnt <= '0;
                ph    <= ph + 1'b1;
                if (ph == 2'd3) begin                   // End of bit period
                    case (state)
                        START: state <= BITS;
                        BITS: begin
                            shift_q <= shift_q << 1;
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BW'(FRAME_BITS - 1)) begin
                                state <= STOP;
                            end
                        end
                        default: state <= IDLE;         // STOP done
                    endcase
                end
            end else begin
                q_cnt <= q_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Line levels per quarter
    //////////////////////////////
    always_comb begin
        scl_d = 1'b1;
        sda_d = 1'b1;
        case (state)
            START: begin                    // sda falls while scl high
                scl_d = (ph != 2'd3);
                sda_d = (ph == 2'd0);
            end
            BITS: begin                     // Data steady while scl high
                scl_d = (ph == 2'd1) || (ph == 2'd2);
                sda_d = shift_q[FRAME_BITS-1];
            end
            STOP: begin                     // sda rises while scl high
                scl_d = (ph != 2'd0);
                sda_d = ph[1];
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/led_ddac.sv
`timescale 1ns/1ps

module led_ddac #(
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic [DEPTH-1:0] count_i,   // Brightness
    output logic             out_o
);
    logic [DEPTH-1:0] acc_q;
    logic [DEPTH:0]   sum;

    // First order modulator, carry is the pulse
    assign sum   = {1'b0, acc_q} + {1'b0, count_i};
    assign out_o = sum[DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            acc_q <= '0;
        end else begin
            acc_q <= sum[DEPTH-1:0];    // Wraps, keeps residue
        end
    end

endmodule

// File: rtl/r24bb_top.sv
`timescale 1ns/1ps
`include "r24bb_settings.svh"

module r24bb_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    // APB
    input  logic                        apb_psel_i,
    input  logic                        apb_penable_i,
    input  logic                        apb_pwrite_i,
    input  logic [`R24BB_DW-1:0]        apb_paddr_i,
    input  logic [`R24BB_DW-1:0]        apb_pwdata_i,
    output logic [`R24BB_DW-1:0]        apb_prdata_o,
    // ADC channel
    input  logic [`R24BB_SAMPLE_W-1:0]  adc_data_i,
    input  logic                        adc_dor_i,
    // USB FIFO side
    output logic [`R24BB_DW-1:0]        usb_wr_data_o,
    output logic [`R24BB_BE_W-1:0]      usb_wr_be_o,
    output logic                        usb_wr_en_o,
    input  logic                        usb_wr_full_i,
    input  logic [`R24BB_DW-1:0]        usb_rd_data_i,
    input  logic [`R24BB_BE_W-1:0]      usb_rd_be_i,
    input  logic                        usb_rd_valid_i,
    input  logic                        usb_rd_empty_i,
    output logic                        usb_rd_en_o,
    // Board
    output logic                        ioexp_scl_o,
    output logic                        ioexp_sda_o,
    output logic                        led0_o,
    output logic                        led1_o
);
    import r24bb_pkg::*;

    usb_src_e                     usb_src;
    logic [`R24BB_DW-1:0]         tx_data;      // Raw register strobes
    logic                         tx_en;
    logic                         rx_pop;
    logic [1:0]                   att;
    logic                         amp_en;
    logic [2:0]                   led;
    logic [`R24BB_LED_DEPTH-1:0]  led0_level;
    logic [`R24BB_LED_DEPTH-1:0]  led1_level;
    logic [`R24BB_SAMPLE_W-1:0]   sample;
    logic                         ovr;
    logic [`R24BB_IOEXP_W-1:0]    ioexp_word;

    //////////////////////////////
    // Control and USB
    //////////////////////////////
    r24bb_regs regs_i (
        .clk, .rst_n_i,
        .apb_psel_i, .apb_penable_i, .apb_pwrite_i, .apb_paddr_i, .apb_pwdata_i, .apb_prdata_o,
        .usb_rd_data_i, .usb_wr_full_i, .usb_rd_empty_i,
        .adc_ovr_i(ovr),
        .usb_src_o(usb_src), .usb_tx_data_o(tx_data), .usb_tx_en_o(tx_en),
        .usb_rx_pop_o(rx_pop),
        .att_o(att), .amp_en_o(amp_en), .led_o(led),
        .led0_level_o(led0_level), .led1_level_o(led1_level)
    );

    usb_route #(.DW(`R24BB_DW), .BE_W(`R24BB_BE_W), .SAMPLE_W(`R24BB_SAMPLE_W)) route_i (
        .usb_src_i(usb_src), .tx_data_i(tx_data), .tx_en_i(tx_en), .rx_pop_i(rx_pop),
        .sample_i(sample),
        .usb_rd_data_i, .usb_rd_be_i, .usb_rd_valid_i, .usb_wr_full_i,
        .usb_wr_data_o, .usb_wr_be_o, .usb_wr_en_o, .usb_rd_en_o
    );

    //////////////////////////////
    // ADC and expander
    //////////////////////////////
    adc_front adc_i (
        .clk, .rst_n_i, .adc_data_i, .adc_dor_i,
        .att_i(att), .amp_en_i(amp_en), .led_i(led),
        .sample_o(sample), .ovr_o(ovr), .ioexp_word_o(ioexp_word)
    );

    ioexp_serial ioexp_i (
        .clk, .rst_n_i, .word_i(ioexp_word), .scl_o(ioexp_scl_o), .sda_o(ioexp_sda_o)
    );

    // Front panel LEDs
    led_ddac #(.DEPTH(`R24BB_LED_DEPTH)) led0_i (
        .clk, .rst_n_i, .count_i(led0_level), .out_o(led0_o)
    );

    led_ddac #(.DEPTH(`R24BB_LED_DEPTH)) led1_i (
        .clk, .rst_n_i, .count_i(led1_level), .out_o(led1_o)
    );

endmodule

// File: dv/r24bb_assertions.sv
`timescale 1ns/1ps

module r24bb_assertions (
    input  logic                clk,
    input  logic                rst_n_i,
    input  r24bb_pkg::usb_src_e usb_src,
    input  logic                tx_en,
    input  logic                usb_wr_en_o,
    input  logic                usb_rd_en_o,
    input  logic                usb_rd_valid_i,
    input  logic                ioexp_scl_o,
    input  logic                ioexp_sda_o
);
    import r24bb_pkg::*;

    //////////////////////////////
    // USB routing
    //////////////////////////////
    idle_quiet_a : assert property (@(posedge clk) disable iff (!rst_n_i)
        (usb_src == USB_SRC_IDLE) |-> (!usb_wr_en_o && !usb_rd_en_o))
        else $error("IDLE mode drove a USB enable");

    push_single_a : assert property (@(posedge clk) disable iff (!rst_n_i)
        tx_en |=> !tx_en)
        else $error("push strobe longer than one cycle");

    // Loopback only writes what was read
    loop_valid_a : assert property (@(posedge clk) disable iff (!rst_n_i)
        ((usb_src == USB_SRC_LOOP) && usb_wr_en_o) |-> usb_rd_valid_i)
        else $error("loopback write without read valid");

    //////////////////////////////
    // Expander lines idle after reset
    //////////////////////////////
    lines_idle_a : assert property (@(posedge clk)
        $rose(rst_n_i) |=> (ioexp_scl_o && ioexp_sda_o))
        else $error("expander lines not idle after reset");

endmodule

bind r24bb_top r24bb_assertions asrt_i (
    .clk, .rst_n_i, .usb_src(usb_src), .tx_en(tx_en),
    .usb_wr_en_o, .usb_rd_en_o, .usb_rd_valid_i, .ioexp_scl_o, .ioexp_sda_o
);

// File: dv/r24bb_tb.sv
`timescale 1ns/1ps
`include "r24bb_settings.svh"

module r24bb_tb;
    logic clk;
    logic rst_n_i;
    logic psel, penable, pwrite;
    logic [`R24BB_DW-1:0] paddr, pwdata, prdata;
    logic [`R24BB_SAMPLE_W-1:0] adc_data;
    logic adc_dor;
    logic [`R24BB_DW-1:0] wr_data, rd_data;
    logic [`R24BB_BE_W-1:0] wr_be, rd_be;
    logic wr_en, wr_full, rd_valid, rd_empty, rd_en;
    logic scl, sda, led0, led1;
    logic [31:0] lfsr_q;
    logic [31:0] rdv;           // Last APB read data
    logic acc_rd_en;            // rd_en seen in last access cycle
    int n_checks, n_errs, test_errs, n_tests;

    r24bb_top dut_i (
        .clk, .rst_n_i,
        .apb_psel_i(psel), .apb_penable_i(penable), .apb_pwrite_i(pwrite),
        .apb_paddr_i(paddr), .apb_pwdata_i(pwdata), .apb_prdata_o(prdata),
        .adc_data_i(adc_data), .adc_dor_i(adc_dor),
        .usb_wr_data_o(wr_data), .usb_wr_be_o(wr_be), .usb_wr_en_o(wr_en),
        .usb_wr_full_i(wr_full), .usb_rd_data_i(rd_data), .usb_rd_be_i(rd_be),
        .usb_rd_valid_i(rd_valid), .usb_rd_empty_i(rd_empty), .usb_rd_en_o(rd_en),
        .ioexp_scl_o(scl), .ioexp_sda_o(sda), .led0_o(led0), .led1_o(led1)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Hard stop if something never returns
    initial begin
        repeat (200000) @(posedge clk);
        $display("simulation watchdog expired");
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////////////////
    // Helpers
    ////////////////////////////////
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hD000_0001) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};      // One step per bit
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            n_errs++;
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s", name, (test_errs == 0) ? "pass" : "fail");
        n_tests++;
        test_errs = 0;
    endtask

    task automatic do_reset();
        @(posedge clk);
        #1 rst_n_i = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst_n_i = 1'b1;
    endtask

    task automatic apb_write(input logic [7:0] off, input logic [31:0] data);
        @(posedge clk);
        #1 psel = 1'b1;                                 // Setup
        pwrite = 1'b1;
        paddr = {`R24BB_PAGE, 12'h0} | off;
        pwdata = data;
        @(posedge clk);
        #1 penable = 1'b1;                              // Access
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read_addr(input logic [31:0] addr);
        @(posedge clk);
        #1 psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        @(posedge clk);
        #1 penable = 1'b1;
        #1 rdv = prdata;                                // Combinational read
        acc_rd_en = rd_en;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] off);
        apb_read_addr({`R24BB_PAGE, 12'h0} | off);
    endtask

    // Word as the expander should see it
    function automatic logic [15:0] exp_word(input logic [5:0] chan, input logic ovr);
        logic [15:0] w;
        logic [2:0]  l;
        w = '0;
        w[1:0] = ~chan[1:0];
        w[2] = chan[2];
        l = ovr ? 3'b100 : chan[5:3];
        w[10:8] = ~l;
        return w;
    endfunction

    // Capture one frame, check address and acks, return the word
    task automatic decode_frame(output logic [15:0] word);
        logic ps, pd, started, done;
        logic [26:0] bits;
        int nb;
        ps = scl;
        pd = sda;
        started = 0;
        done = 0;
        nb = 0;
        bits = '0;
        for (int t = 0; t < 4000 && !done; t++) begin
            @(posedge clk);
            #2;
            if (!started) begin
                started = ps && scl && pd && !sda;      // Start condition
            end else if (nb < 27 && !ps && scl) begin
                bits = {bits[25:0], sda};
                nb++;
            end else if (nb == 27 && ps && scl && !pd && sda) begin
                done = 1;                               // Stop condition
            end
            ps = scl;
            pd = sda;
        end
        if (!done) begin
            $display("timeout waiting for a complete expander frame");
            n_errs++;
            test_errs++;
        end
        check_val("ioexp_addr", bits[26:20], `R24BB_IOEXP_ADDR);
        check_val("ioexp_rw", bits[19], 0);
        check_val("ioexp_acks", {bits[18], bits[9], bits[0]}, 3'b111);
        word = {bits[8:1], bits[17:10]};
    endtask

    ////////////////////////////////
    // Tests
    ////////////////////////////////
    task automatic test_regs();
        logic [31:0] v;
        logic [7:0] offs [4] = '{8'h00, 8'h04, 8'h08, 8'h0C};
        logic [31:0] widths [4] = '{2, 6, 16, 16};
        foreach (offs[i]) begin
            apb_read(offs[i]);
            check_val("reset_value", rdv, 0);
        end
        for (int r = 0; r < 4; r++) begin
            foreach (offs[i]) begin
                rand_bits(widths[i], v);
                apb_write(offs[i], v);
                apb_read(offs[i]);
                check_val("readback", rdv, v);
            end
        end
        apb_write(8'h00, 0);                            // Back to REGS
        apb_read_addr(32'h1234_0004);
        check_val("off_page", rdv, 0);
        end_test("registers");
    endtask

    task automatic test_push_idle();
        logic [31:0] v;
        rand_bits(32, v);
        apb_write(8'h10, v);
        #1 check_val("wr_en", wr_en, 1);
        check_val("wr_data", wr_data, v);
        check_val("wr_be", wr_be, 4'hF);
        @(posedge clk);
        #2 check_val("wr_en_after", wr_en, 0);
        apb_write(8'h00, 1);                            // IDLE
        apb_write(8'h10, v);
        for (int i = 0; i < 4; i++) begin
            #1 check_val("idle_enables", {wr_en, rd_en}, 0);
            @(posedge clk);
        end
        apb_write(8'h00, 0);
        end_test("push_idle");
    endtask

    task automatic test_pop_loop();
        logic [31:0] v;
        rand_bits(32, v);
        rd_data = v;
        apb_read(8'h14);
        check_val("rx_data", rdv, v);
        check_val("rd_en_access", acc_rd_en, 1);
        #1 check_val("rd_en_after", rd_en, 0);
        apb_write(8'h00, 3);                            // LOOP
        rand_bits(32, v);
        rd_data = v;
        rand_bits(4, v);
        rd_be = v[3:0];
        rd_valid = 1'b1;
        #1 check_val("loop_data", wr_data, rd_data);
        check_val("loop_be", wr_be, rd_be);
        check_val("loop_enables", {wr_en, rd_en}, 2'b11);
        wr_full = 1'b1;
        #1 check_val("loop_stall", rd_en, 0);
        rd_valid = 1'b0;
        wr_full = 1'b0;
        #1 check_val("loop_no_valid", wr_en, 0);
        apb_write(8'h00, 0);
        end_test("pop_loop");
    endtask

    task automatic test_adc_status();
        logic [31:0] v;
        logic [7:0] prev;
        apb_write(8'h00, 2);                            // ADC
        rand_bits(8, v);
        adc_data = v[7:0];
        prev = v[7:0];
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1 rand_bits(8, v);
            adc_data = v[7:0];
            #1 check_val("adc_wr_data", wr_data, prev);
            check_val("adc_enables", {wr_en, rd_en}, 2'b11);
            prev = v[7:0];
        end
        apb_write(8'h00, 0);
        wr_full = 1'b1;
        rd_empty = 1'b0;
        apb_read(8'h18);
        check_val("status_full", rdv, 1);
        wr_full = 1'b0;
        rd_empty = 1'b1;
        apb_read(8'h18);
        check_val("status_empty", rdv, 2);
        rd_empty = 1'b0;
        adc_dor = 1'b1;
        @(posedge clk);
        #1 adc_dor = 1'b0;
        apb_read(8'h18);
        check_val("status_ovr", rdv, 4);
        repeat (`R24BB_DOR_HOLD + 4) @(posedge clk);
        apb_read(8'h18);
        check_val("status_clear", rdv, 0);
        end_test("adc_status");
    endtask

    task automatic test_expander();
        logic [15:0] w;
        logic [31:0] chan;
        do_reset();
        decode_frame(w);
        check_val("ioexp_first", w, exp_word(6'h0, 1'b0));
        rand_bits(6, chan);
        chan[3] = 1'b1;             // Blue on, word differs from reset and from forced red
        apb_write(8'h04, chan);
        decode_frame(w);
        check_val("ioexp_chan", w, exp_word(chan[5:0], 1'b0));
        @(posedge clk);
        #1 adc_dor = 1'b1;                              // Forces red
        @(posedge clk);
        #1 adc_dor = 1'b0;
        decode_frame(w);
        check_val("ioexp_ovr", w, exp_word(chan[5:0], 1'b1));
        decode_frame(w);
        check_val("ioexp_restore", w, exp_word(chan[5:0], 1'b0));
        end_test("expander");
    endtask

    task automatic test_leds();
        int highs;
        do_reset();
        apb_write(8'h08, 32'h4000);
        highs = 0;
        for (int i = 0; i < 64; i++) begin
            highs += led0;
            check_val("led1_dark", led1, 0);
            @(posedge clk);
            #1;
        end
        check_val("led0_highs", highs, 16);
        apb_write(8'h08, 0);
        highs = 0;
        for (int i = 0; i < 64; i++) begin
            highs += led0;
            @(posedge clk);
            #1;
        end
        check_val("led0_zero", highs, 0);
        end_test("leds");
    endtask

    initial begin
        lfsr_q = 32'h4f829fb6;
        n_checks = 0;
        n_errs = 0;
        test_errs = 0;
        n_tests = 0;
        rst_n_i = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        adc_data = '0;
        adc_dor = 1'b0;
        wr_full = 1'b0;
        rd_data = '0;
        rd_be = '0;
        rd_valid = 1'b0;
        rd_empty = 1'b1;
        do_reset();
        test_regs();
        test_push_idle();
        test_pop_loop();
        test_adc_status();
        test_expander();
        test_leds();
        $display("tests %0d checks %0d errors %0d", n_tests, n_checks, n_errs);
        if (n_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: r24bb.f
+incdir+rtl
rtl/r24bb_pkg.sv
rtl/r24bb_regs.sv
rtl/usb_route.sv
rtl/adc_front.sv
rtl/ioexp_serial.sv
rtl/led_ddac.sv
rtl/r24bb_top.sv
dv/r24bb_assertions.sv
dv/r24bb_tb.sv

// File: Makefile
TOP := r24bb_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f r24bb.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "NO ERRORS"

lint:
	verilator --lint-only --timing -Wall -f r24bb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
